/* hw/link_pkg.sv */
package link_pkg;

    // Basic data widths
    typedef logic [7:0] byte_t;        // One serial data byte
    typedef logic [5:0] pins_t;        // Output pin levels
    typedef logic [7:0] baud_cnt_t;    // Cycles within one bit period

    // Serial timing
    localparam int CLKS_PER_BIT = 16;  // 48 on the board for 1 Mbaud at 48 MHz
    localparam logic PARITY_EN = 1'b1; // Even parity sent and checked

    // Bit period end and first sample point, counted from zero
    localparam baud_cnt_t BIT_LAST = baud_cnt_t'(CLKS_PER_BIT - 1);
    localparam baud_cnt_t BIT_MID  = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);

    // Start-up hold, one second of cycles on the board
    localparam int STARTUP_CYCLES = 64;
    localparam int STARTUP_CNT_W  = $clog2(STARTUP_CYCLES);
    typedef logic [STARTUP_CNT_W-1:0] startup_cnt_t;
    localparam startup_cnt_t STARTUP_LAST = startup_cnt_t'(STARTUP_CYCLES - 1);

    // Receive FIFO sizing
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;  // Holds 0 up to FIFO_DEPTH
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;
    localparam fifo_cnt_t FIFO_FULL = fifo_cnt_t'(FIFO_DEPTH);

    // Reply codes
    localparam byte_t ACK_CODE  = 8'h3C;  // Data command taken
    localparam byte_t NACK_CODE = 8'hC3;  // Anything else

    // Receiver output, valid is a single-cycle strobe
    typedef struct packed {
        byte_t data;
        logic  valid;
    } rx_byte_s;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        CMD_IDLE,
        CMD_SEND,
        CMD_WAIT_DONE
    } cmd_state_e;

endpackage

/* hw/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,          // Low holds the receiver idle
    input  logic               rx,          // Serial line from host
    output link_pkg::rx_byte_s rx_byte,
    output logic               parity_err   // One-cycle pulse, byte dropped
);

    link_pkg::rx_state_e state;
    link_pkg::baud_cnt_t baud_cnt;
    link_pkg::byte_t     shift_q;

    logic [2:0] bit_idx;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    logic       par_acc;     // Running xor over data and parity bits
    logic       valid_q;
    logic       start_edge;
    logic       mid_hit;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = rx_prev & ~rx_sync;  // Falling edge, start bit begins

    // Half a bit into the start bit, then one full bit per sample
    assign mid_hit = (state == link_pkg::RX_START) ? (baud_cnt == link_pkg::BIT_MID)
                                                   : (baud_cnt == link_pkg::BIT_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= link_pkg::RX_IDLE;
            baud_cnt   <= '0;
            bit_idx    <= '0;
            par_acc    <= 1'b0;
            valid_q    <= 1'b0;
            parity_err <= 1'b0;
        end else if (!en) begin
            state      <= link_pkg::RX_IDLE;
            baud_cnt   <= '0;
            bit_idx    <= '0;
            par_acc    <= 1'b0;
            valid_q    <= 1'b0;
            parity_err <= 1'b0;
        end else begin
            valid_q    <= 1'b0;  // Strobes last one cycle
            parity_err <= 1'b0;
            if (state != link_pkg::RX_IDLE) begin
                baud_cnt <= mid_hit ? '0 : baud_cnt + 1'b1;
            end
            case (state)
                link_pkg::RX_IDLE: begin
                    if (start_edge) begin
                        state <= link_pkg::RX_START;
                    end
                end
                link_pkg::RX_START: begin
                    if (mid_hit) begin
                        bit_idx <= '0;
                        par_acc <= 1'b0;
                        // Line back high at mid start bit means a glitch
                        state   <= rx_sync ? link_pkg::RX_IDLE : link_pkg::RX_DATA;
                    end
                end
                link_pkg::RX_DATA: begin
                    if (mid_hit) begin
                        par_acc <= par_acc ^ rx_sync;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= link_pkg::PARITY_EN ? link_pkg::RX_PARITY
                                                         : link_pkg::RX_STOP;
                        end
                    end
                end
                link_pkg::RX_PARITY: begin
                    if (mid_hit) begin
                        par_acc <= par_acc ^ rx_sync;  // Zero now if parity is even
                        state   <= link_pkg::RX_STOP;
                    end
                end
                link_pkg::RX_STOP: begin
                    if (mid_hit) begin
                        state <= link_pkg::RX_IDLE;
                        // Low stop bit is a framing error, byte silently lost
                        if (rx_sync) begin
                            if (link_pkg::PARITY_EN && par_acc) begin
                                parity_err <= 1'b1;
                            end else begin
                                valid_q <= 1'b1;
                            end
                        end
                    end
                end
                default: state <= link_pkg::RX_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first, shifted in from the top
    always_ff @(posedge clk) begin
        if (en && state == link_pkg::RX_DATA && mid_hit) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
    end

    // Shift register holds still until the next frame's data bits
    assign rx_byte = '{data: shift_q, valid: valid_q};

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    input  link_pkg::byte_t tx_data,
    input  logic            start_tx,  // Only honoured while idle
    output logic            tx,
    output logic            busy       // High for the whole frame
);

    link_pkg::tx_state_e state;
    link_pkg::baud_cnt_t baud_cnt;
    link_pkg::byte_t     shift_q;

    logic [2:0] bit_idx;
    logic       parity_q;
    logic       bit_end;
    logic       load;

    assign bit_end = (baud_cnt == link_pkg::BIT_LAST);
    assign load    = en && start_tx && (state == link_pkg::TX_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= link_pkg::TX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;  // Line idles high
            busy     <= 1'b0;
        end else if (!en) begin
            state    <= link_pkg::TX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;
            busy     <= 1'b0;
        end else begin
            if (state != link_pkg::TX_IDLE) begin
                baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            end
            case (state)
                link_pkg::TX_IDLE: begin
                    if (start_tx) begin
                        state <= link_pkg::TX_START;
                        tx    <= 1'b0;  // Start bit
                        busy  <= 1'b1;
                    end
                end
                link_pkg::TX_START: begin
                    if (bit_end) begin
                        state   <= link_pkg::TX_DATA;
                        bit_idx <= '0;
                        tx      <= shift_q[0];
                    end
                end
                link_pkg::TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            if (link_pkg::PARITY_EN) begin
                                state <= link_pkg::TX_PARITY;
                                tx    <= parity_q;
                            end else begin
                                state <= link_pkg::TX_STOP;
                                tx    <= 1'b1;
                            end
                        end else begin
                            tx <= shift_q[1];  // Next bit, before the shift lands
                        end
                    end
                end
                link_pkg::TX_PARITY: begin
                    if (bit_end) begin
                        state <= link_pkg::TX_STOP;
                        tx    <= 1'b1;
                    end
                end
                link_pkg::TX_STOP: begin
                    if (bit_end) begin
                        state <= link_pkg::TX_IDLE;
                        busy  <= 1'b0;  // Frame done
                    end
                end
                default: state <= link_pkg::TX_IDLE;
            endcase
        end
    end

    // Frame payload
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q  <= tx_data;
            parity_q <= ^tx_data;  // Even parity
        end else if (en && state == link_pkg::TX_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

/* hw/byte_fifo.sv */
`timescale 1ns/1ns

module byte_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  link_pkg::rx_byte_s wr,         // Write on wr.valid
    input  logic               rd_en,      // Pop, data taken same cycle
    output link_pkg::byte_t    rd_data,
    output logic               not_empty,
    output logic               overflow    // Write lost to a full FIFO
);

    link_pkg::byte_t     mem [link_pkg::FIFO_DEPTH];
    link_pkg::fifo_ptr_t wr_ptr;
    link_pkg::fifo_ptr_t rd_ptr;
    link_pkg::fifo_cnt_t count;

    logic full;
    logic do_wr;
    logic do_rd;

    assign full      = (count == link_pkg::FIFO_FULL);
    assign not_empty = (count != '0);
    assign do_rd     = rd_en && not_empty;
    assign do_wr     = wr.valid && !full;  // Strict, no write-through when full
    assign rd_data   = mem[rd_ptr];        // Head of queue

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else if (!en) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= wr.valid && full;
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, wraps
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (en && do_wr) begin
            mem[wr_ptr] <= wr.data;
        end
    end

endmodule

/* hw/cmd_handler.sv */
`timescale 1ns/1ns

module cmd_handler (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    input  logic            not_empty,
    input  link_pkg::byte_t rd_data,
    output logic            rd_en,      // One-cycle pop
    output link_pkg::byte_t tx_data,    // Reply byte
    output logic            start_tx,
    input  logic            busy,
    output link_pkg::pins_t pins,
    output logic            toggle      // Flips per accepted data command
);

    link_pkg::cmd_state_e state;

    logic is_data;

    // Data command when the two top bits are clear
    assign is_data = (rd_data[7:6] == 2'b00);

    // Pop only when a byte waits and the transmitter is free
    assign rd_en = en && (state == link_pkg::CMD_IDLE) && not_empty && !busy;

    // Reply start one cycle after the pop
    assign start_tx = (state == link_pkg::CMD_SEND);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= link_pkg::CMD_IDLE;
            pins   <= '0;
            toggle <= 1'b0;
        end else if (!en) begin
            state <= link_pkg::CMD_IDLE;  // Pins keep their level
        end else begin
            case (state)
                link_pkg::CMD_IDLE: begin
                    if (rd_en) begin
                        state <= link_pkg::CMD_SEND;
                        if (is_data) begin
                            pins   <= rd_data[5:0];
                            toggle <= ~toggle;
                        end
                    end
                end
                link_pkg::CMD_SEND: begin
                    // Transmitter raises busy next cycle
                    state <= link_pkg::CMD_WAIT_DONE;
                end
                link_pkg::CMD_WAIT_DONE: begin
                    if (!busy) begin
                        state <= link_pkg::CMD_IDLE;  // Reply frame finished
                    end
                end
                default: state <= link_pkg::CMD_IDLE;
            endcase
        end
    end

    // Reply code picked in the pop cycle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            tx_data <= is_data ? link_pkg::ACK_CODE : link_pkg::NACK_CODE;
        end
    end

endmodule

/* hw/link_node.sv */
`timescale 1ns/1ns

module link_node (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rx,          // From host
    output logic            tx,          // To host
    output link_pkg::pins_t pins,
    output logic            led_ready,   // Blue
    output logic            led_error,   // Red, sticky until reset
    output logic            led_toggle   // Green
);

    link_pkg::startup_cnt_t start_cnt;
    link_pkg::rx_byte_s     rx_byte;
    link_pkg::byte_t        fifo_data;
    link_pkg::byte_t        tx_data;

    logic link_run;     // Serial path enabled
    logic parity_err;
    logic overflow;
    logic fifo_not_empty;
    logic fifo_rd_en;
    logic start_tx;
    logic tx_busy;

    // Start-up hold, counter parks once the link runs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_cnt <= '0;
            link_run  <= 1'b0;
        end else if (!link_run) begin
            start_cnt <= start_cnt + 1'b1;
            if (start_cnt == link_pkg::STARTUP_LAST) begin
                link_run <= 1'b1;  // Rises STARTUP_CYCLES after release
            end
        end
    end

    assign led_ready = link_run;

    // Error latch for dropped bytes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_error <= 1'b0;
        end else if (parity_err || overflow) begin
            led_error <= 1'b1;
        end
    end

    uart_rx rx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (link_run),
        .rx         (rx),
        .rx_byte    (rx_byte),
        .parity_err (parity_err)
    );

    byte_fifo fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (link_run),
        .wr        (rx_byte),
        .rd_en     (fifo_rd_en),
        .rd_data   (fifo_data),
        .not_empty (fifo_not_empty),
        .overflow  (overflow)
    );

    cmd_handler cmd_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (link_run),
        .not_empty (fifo_not_empty),
        .rd_data   (fifo_data),
        .rd_en     (fifo_rd_en),
        .tx_data   (tx_data),
        .start_tx  (start_tx),
        .busy      (tx_busy),
        .pins      (pins),
        .toggle    (led_toggle)
    );

    uart_tx tx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (link_run),
        .tx_data  (tx_data),
        .start_tx (start_tx),
        .tx       (tx),
        .busy     (tx_busy)
    );

endmodule

/* test/link_checker.sv */
`timescale 1ns/1ns

module link_checker (
    input logic            clk,
    input logic            rst_n,
    input logic            tx,          // Reply line from the DUT
    input link_pkg::pins_t pins,
    input logic            led_ready,
    input logic            led_error,
    input logic            led_toggle
);

    typedef struct packed {
        link_pkg::byte_t code;
        link_pkg::pins_t pins;     // Pin levels once the command is taken
        logic            toggle;
    } reply_s;

    reply_s exp_q[$];              // Filled by the testbench, in send order
    int     outstanding = 0;       // Replies still owed
    int     value_errors = 0;
    int     protocol_errors = 0;
    int     run_cycles = 0;        // Cycles since reset release
    logic   error_seen = 1'b0;

    task automatic expect_reply(input link_pkg::byte_t code, input link_pkg::pins_t p,
                                input logic t);
        exp_q.push_back('{code: code, pins: p, toggle: t});
        outstanding = exp_q.size();
    endtask

    task automatic mismatch(input string what, input logic [7:0] got, input logic [7:0] want);
        value_errors++;
        $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
    endtask

    // Levels while the link is quiet
    task automatic check_levels(input link_pkg::pins_t p, input logic t, input logic e);
        @(negedge clk);
        if (pins !== p) mismatch("pins", pins, p);
        if (led_toggle !== t) mismatch("led_toggle", led_toggle, t);
        if (led_error !== e) mismatch("led_error", led_error, e);
    endtask

    // Ready LED timing and the sticky error LED, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n !== 1'b1) begin
            run_cycles = 0;
        end else begin
            run_cycles++;
            if (led_ready !== (run_cycles > link_pkg::STARTUP_CYCLES))
                mismatch("led_ready", led_ready, run_cycles > link_pkg::STARTUP_CYCLES);
            if (error_seen && led_error !== 1'b1) mismatch("led_error", led_error, 1'b1);
            error_seen = error_seen | (led_error === 1'b1);
        end
    end

    // Reply frames decoded at mid-bit
    initial begin : reply_decoder
        link_pkg::byte_t data;
        logic            par;
        logic            stop;
        reply_s          exp;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && tx === 1'b0) begin
                repeat (link_pkg::CLKS_PER_BIT / 2) @(negedge clk);  // Middle of start bit
                for (int i = 0; i < 8; i++) begin
                    repeat (link_pkg::CLKS_PER_BIT) @(negedge clk);
                    data[i] = tx;  // LSB first
                end
                repeat (link_pkg::CLKS_PER_BIT) @(negedge clk);
                par = tx;
                repeat (link_pkg::CLKS_PER_BIT) @(negedge clk);
                stop = tx;
                if (stop !== 1'b1) begin
                    protocol_errors++;
                    $display("Reply frame ending at %0t ns has a low stop bit", $time);
                end
                if (par !== ^data) mismatch("reply parity bit", par, ^data);  // Even parity
                if (exp_q.size() == 0) begin
                    protocol_errors++;
                    $display("Reply 0x%02h at %0t ns arrived with no command waiting", data, $time);
                end else begin
                    exp = exp_q.pop_front();
                    if (data !== exp.code) mismatch("reply code", data, exp.code);
                    if (pins !== exp.pins) mismatch("pins", pins, exp.pins);
                    if (led_toggle !== exp.toggle) mismatch("led_toggle", led_toggle, exp.toggle);
                    outstanding = exp_q.size();
                end
            end
        end
    end

endmodule

/* test/link_node_tb.sv */
`timescale 1ns/1ns

module link_node_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int FRAME_CYCLES = 11 * link_pkg::CLKS_PER_BIT;  // Start, data, parity, stop
    localparam int NUM_RANDOM   = 8;
    localparam int NUM_FRAMES   = NUM_RANDOM + 6;  // Early, bad parity, burst of 3, last
    localparam int WATCHDOG_NS  = (NUM_FRAMES * 2 * FRAME_CYCLES + link_pkg::STARTUP_CYCLES
                                   + 500) * CLK_PERIOD;

    logic            clk;
    logic            rst_n;
    logic            rx;
    logic            tx;
    link_pkg::pins_t pins;
    logic            led_ready;
    logic            led_error;
    logic            led_toggle;

    link_pkg::pins_t exp_pins;     // Model of the pin levels
    logic            exp_toggle;
    int              seed;

    link_node dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx         (rx),
        .tx         (tx),
        .pins       (pins),
        .led_ready  (led_ready),
        .led_error  (led_error),
        .led_toggle (led_toggle)
    );

    link_checker checker_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx         (dut_i.tx),
        .pins       (dut_i.pins),
        .led_ready  (dut_i.led_ready),
        .led_error  (dut_i.led_error),
        .led_toggle (dut_i.led_toggle)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Expected reply for a command byte and the pin model after it
    function automatic link_pkg::byte_t ref_reply(input link_pkg::byte_t cmd,
                                                  inout link_pkg::pins_t p, inout logic t);
        if (cmd[7:6] == 2'b00) begin
            p = cmd[5:0];
            t = ~t;
            return 8'h3C;  // ACK
        end
        return 8'hC3;      // NACK
    endfunction

    // Host frame with data LSB first and an optional bad parity bit
    task automatic send_frame(input link_pkg::byte_t data, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (link_pkg::CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic send_command(input link_pkg::byte_t cmd);
        link_pkg::byte_t code;
        code = ref_reply(cmd, exp_pins, exp_toggle);
        checker_i.expect_reply(code, exp_pins, exp_toggle);  // Queued before the frame goes out
        send_frame(cmd, 1'b0);
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : stimulus
        link_pkg::byte_t cmd;
        int              total;
        seed       = 32'hbf3;
        exp_pins   = '0;
        exp_toggle = 1'b0;
        rst_n      = 1'b0;
        rx         = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        // 0xF8 has its only falling edge in the hold, so nothing is received
        send_frame(8'hF8, 1'b0);
        wait (led_ready === 1'b1);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            cmd = link_pkg::byte_t'($random(seed));
            if (i % 2 == 0) begin
                cmd[7:6] = 2'b00;  // Every other one a data command
            end else if (cmd[7:6] == 2'b00) begin
                cmd[7] = 1'b1;     // The rest never are
            end
            send_command(cmd);
            wait (checker_i.outstanding == 0);
        end
        checker_i.check_levels(exp_pins, exp_toggle, 1'b0);
        // Bad parity on a data byte that would flip every pin
        send_frame({2'b00, ~exp_pins}, 1'b1);
        wait (led_error === 1'b1);
        repeat (FRAME_CYCLES) @(posedge clk);  // Long enough for a wrong reply to show
        checker_i.check_levels(exp_pins, exp_toggle, 1'b1);
        for (int i = 0; i < 3; i++) begin
            cmd = link_pkg::byte_t'($random(seed));
            if (i != 1) cmd[7:6] = 2'b00;
            send_command(cmd);  // Frames follow with no idle gap
        end
        wait (checker_i.outstanding == 0);
        send_command({2'b00, ~exp_pins});
        wait (checker_i.outstanding == 0);
        repeat (FRAME_CYCLES) @(posedge clk);  // Room for a stray reply
        checker_i.check_levels(exp_pins, exp_toggle, 1'b1);
        total = checker_i.value_errors + checker_i.protocol_errors;
        $display("Errors: %0d value mismatches, %0d protocol errors",
                 checker_i.value_errors, checker_i.protocol_errors);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* link_node.f */
hw/link_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/byte_fifo.sv
hw/cmd_handler.sv
hw/link_node.sv
test/link_checker.sv
test/link_node_tb.sv

/* Bender.yml */
package:
  name: link_node

sources:
  # RTL, package first
  - hw/link_pkg.sv
  - hw/uart_rx.sv
  - hw/uart_tx.sv
  - hw/byte_fifo.sv
  - hw/cmd_handler.sv
  - hw/link_node.sv
  # Testbench
  - target: test
    files:
      - test/link_checker.sv
      - test/link_node_tb.sv
